// ==== core_region_defines.svh ====
`ifndef CORE_REGION_DEFINES_SVH
`define CORE_REGION_DEFINES_SVH

// load/store side word
`define CR_WORD_W      32
`define CR_BE_W        4

// data RAM and host side line
`define CR_LINE_W      64
`define CR_LINE_BE_W   8

// data RAM size in bytes and byte address width inside it
`define CR_RAM_BYTES   4096
`define CR_RAM_ADDR_W  12

// page bits that pick local RAM or the external bus
`define CR_PAGE_MSB    31
`define CR_PAGE_LSB    20

// page value of the on-chip data RAM
`define CR_LOCAL_PAGE  12'h001

`endif

// ==== core_region_pkg.sv ====
`include "core_region_defines.svh"

package core_region_pkg;

  // 32-bit load/store request as issued by the core
  typedef struct packed {
    logic [`CR_WORD_W-1:0] addr;
    logic                  we;
    logic [`CR_BE_W-1:0]   be;
    logic [`CR_WORD_W-1:0] wdata;
  } lsu_req_t;

  // full line request, used by the host port and the RAM itself
  // addr is a byte address inside the RAM
  typedef struct packed {
    logic [`CR_RAM_ADDR_W-1:0] addr;
    logic                      we;
    logic [`CR_LINE_BE_W-1:0]  be;
    logic [`CR_LINE_W-1:0]     wdata;
  } line_req_t;

  // where the pending load/store response comes from
  typedef enum logic [0:0] {
    RESP_RAM = 1'b0,
    RESP_EXT = 1'b1
  } resp_src_e;

endpackage

// ==== lsu_demux.sv ====
`timescale 1ns/1ns

`include "core_region_defines.svh"

module lsu_demux import core_region_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // load/store port
  input  logic                  lsu_req_i,
  input  lsu_req_t              lsu_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output logic [`CR_WORD_W-1:0] lsu_rdata_o,

  // local RAM branch, payload is taken from lsu_i at the top level
  output logic                  ram_req_o,
  input  logic                  ram_gnt_i,
  input  logic                  ram_rvalid_i,
  input  logic [`CR_WORD_W-1:0] ram_rdata_i,

  // external bus branch
  output logic                  ext_req_o,
  output lsu_req_t              ext_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  input  logic [`CR_WORD_W-1:0] ext_rdata_i
);

  logic      is_local;
  resp_src_e resp_src_q;
  resp_src_e resp_src_d;

  // decode the page bits
  assign is_local  = (lsu_i.addr[`CR_PAGE_MSB:`CR_PAGE_LSB] == `CR_LOCAL_PAGE);

  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // the external bus sees the request unchanged
  assign ext_o     = lsu_i;

  // take the grant of the selected branch and note who will answer
  always_comb
  begin
    lsu_gnt_o  = 1'b0;
    resp_src_d = resp_src_q;
    if (ext_req_o)
    begin
      lsu_gnt_o = ext_gnt_i;
      if (ext_gnt_i)
        resp_src_d = RESP_EXT;
    end
    else if (ram_req_o)
    begin
      lsu_gnt_o = ram_gnt_i;
      if (ram_gnt_i)
        resp_src_d = RESP_RAM;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      resp_src_q <= RESP_RAM;
    else
      resp_src_q <= resp_src_d;
  end

  // merge both response streams back onto the load/store port
  assign lsu_rdata_o  = (resp_src_q == RESP_EXT) ? ext_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;

  // only one branch may answer at a time
  assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_rvalid_i && ext_rvalid_i))
  else $error("lsu_demux: RAM and external responses overlap");

  // an external response must belong to a request the external bus granted
  assert property (@(posedge clk) disable iff (!rst_n)
    ext_rvalid_i |-> (resp_src_q == RESP_EXT))
  else $error("lsu_demux: external response without external grant");

endmodule

// ==== data_ram_arbiter.sv ====
`timescale 1ns/1ns

`include "core_region_defines.svh"

module data_ram_arbiter import core_region_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // host port with full lines and no stall
  input  logic                  host_req_i,
  input  line_req_t             host_i,
  output logic [`CR_LINE_W-1:0] host_rdata_o,

  // load/store port with 32-bit words
  input  logic                  lsu_req_i,
  input  lsu_req_t              lsu_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output logic [`CR_WORD_W-1:0] lsu_rdata_o,

  // single RAM port
  output logic                  ram_en_o,
  output line_req_t             ram_o,
  input  logic [`CR_LINE_W-1:0] ram_rdata_i
);

  logic      lsu_lane;
  line_req_t lsu_line;
  logic      lsu_lane_q;
  logic      lsu_rvalid_q;

  // address bit 2 picks the upper or lower word of a line
  assign lsu_lane = lsu_i.addr[2];

  // widen the load/store word to a line request
  always_comb
  begin
    lsu_line.addr  = {lsu_i.addr[`CR_RAM_ADDR_W-1:3], 3'b000};
    lsu_line.we    = lsu_i.we;
    lsu_line.wdata = {2{lsu_i.wdata}};
    if (lsu_lane)
      lsu_line.be = {lsu_i.be, {`CR_BE_W{1'b0}}};
    else
      lsu_line.be = {{`CR_BE_W{1'b0}}, lsu_i.be};
  end

  // host wins and load/store waits while the host requests
  assign lsu_gnt_o = lsu_req_i & ~host_req_i;
  assign ram_en_o  = host_req_i | lsu_req_i;

  always_comb
  begin
    if (host_req_i)
      ram_o = host_i;
    else
      ram_o = lsu_line;
  end

  // remember the granted lane so the returned line can be cut back
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lsu_rvalid_q <= 1'b0;
      lsu_lane_q   <= 1'b0;
    end
    else
    begin
      lsu_rvalid_q <= lsu_gnt_o;
      if (lsu_gnt_o)
        lsu_lane_q <= lsu_lane;
    end
  end

  assign lsu_rvalid_o = lsu_rvalid_q;

  always_comb
  begin
    if (lsu_lane_q)
      lsu_rdata_o = ram_rdata_i[`CR_LINE_W-1:`CR_WORD_W];
    else
      lsu_rdata_o = ram_rdata_i[`CR_WORD_W-1:0];
  end

  // the host sees the whole registered line
  assign host_rdata_o = ram_rdata_i;

  // the host keeps the RAM to itself
  assert property (@(posedge clk) disable iff (!rst_n)
    host_req_i |-> !lsu_gnt_o)
  else $error("data_ram_arbiter: load/store granted during host access");

endmodule

// ==== data_ram.sv ====
`timescale 1ns/1ns

`include "core_region_defines.svh"

module data_ram import core_region_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en_i,
  input  line_req_t             req_i,
  output logic [`CR_LINE_W-1:0] rdata_o
);

  localparam int unsigned NUM_LINES = `CR_RAM_BYTES / 8;

  logic [`CR_LINE_W-1:0]      mem [NUM_LINES];
  logic [`CR_RAM_ADDR_W-4:0]  line_idx;

  // line index, byte offset inside the line is dropped
  assign line_idx = req_i.addr[`CR_RAM_ADDR_W-1:3];

  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (req_i.we)
      begin
        for (int b = 0; b < `CR_LINE_BE_W; b++)
        begin
          if (req_i.be[b])
            mem[line_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
      // read is registered, old contents on a write
      rdata_o <= mem[line_idx];
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    en_i |-> !$isunknown(req_i.addr))
  else $error("data_ram: unknown address while enabled");

endmodule

// ==== core_region_top.sv ====
`timescale 1ns/1ns

`include "core_region_defines.svh"

module core_region_top import core_region_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // load/store port
  input  logic                  lsu_req_i,
  input  lsu_req_t              lsu_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output logic [`CR_WORD_W-1:0] lsu_rdata_o,

  // external bus port
  output logic                  ext_req_o,
  output lsu_req_t              ext_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  input  logic [`CR_WORD_W-1:0] ext_rdata_i,

  // host port into the data RAM
  input  logic                  host_req_i,
  input  line_req_t             host_i,
  output logic [`CR_LINE_W-1:0] host_rdata_o
);

  logic                  ram_lsu_req;
  logic                  ram_lsu_gnt;
  logic                  ram_lsu_rvalid;
  logic [`CR_WORD_W-1:0] ram_lsu_rdata;

  logic                  ram_en;
  line_req_t             ram_req;
  logic [`CR_LINE_W-1:0] ram_rdata;

  lsu_demux i_lsu_demux (
    .clk          ( clk            ),
    .rst_n        ( rst_n          ),
    .lsu_req_i    ( lsu_req_i      ),
    .lsu_i        ( lsu_i          ),
    .lsu_gnt_o    ( lsu_gnt_o      ),
    .lsu_rvalid_o ( lsu_rvalid_o   ),
    .lsu_rdata_o  ( lsu_rdata_o    ),
    .ram_req_o    ( ram_lsu_req    ),
    .ram_gnt_i    ( ram_lsu_gnt    ),
    .ram_rvalid_i ( ram_lsu_rvalid ),
    .ram_rdata_i  ( ram_lsu_rdata  ),
    .ext_req_o    ( ext_req_o      ),
    .ext_o        ( ext_o          ),
    .ext_gnt_i    ( ext_gnt_i      ),
    .ext_rvalid_i ( ext_rvalid_i   ),
    .ext_rdata_i  ( ext_rdata_i    )
  );

  // local branch, request payload comes straight from the load/store port
  data_ram_arbiter i_data_ram_arbiter (
    .clk          ( clk            ),
    .rst_n        ( rst_n          ),
    .host_req_i   ( host_req_i     ),
    .host_i       ( host_i         ),
    .host_rdata_o ( host_rdata_o   ),
    .lsu_req_i    ( ram_lsu_req    ),
    .lsu_i        ( lsu_i          ),
    .lsu_gnt_o    ( ram_lsu_gnt    ),
    .lsu_rvalid_o ( ram_lsu_rvalid ),
    .lsu_rdata_o  ( ram_lsu_rdata  ),
    .ram_en_o     ( ram_en         ),
    .ram_o        ( ram_req        ),
    .ram_rdata_i  ( ram_rdata      )
  );

  data_ram i_data_ram (
    .clk     ( clk       ),
    .rst_n   ( rst_n     ),
    .en_i    ( ram_en    ),
    .req_i   ( ram_req   ),
    .rdata_o ( ram_rdata )
  );

endmodule

// ==== tb_core_region_checks.svh ====
`ifndef TB_CORE_REGION_CHECKS_SVH
`define TB_CORE_REGION_CHECKS_SVH

task automatic check_word(input string name, input logic [`CR_WORD_W-1:0] exp_val,
                          input logic [`CR_WORD_W-1:0] act_val);
  if (act_val !== exp_val)
  begin
    $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
    fail_stop();
  end
endtask

task automatic check_line(input string name, input logic [`CR_LINE_W-1:0] exp_val,
                          input logic [`CR_LINE_W-1:0] act_val);
  if (act_val !== exp_val)
  begin
    $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
    fail_stop();
  end
endtask

task automatic check_src(input string name, input resp_src_e exp_val, input resp_src_e act_val);
  if (act_val !== exp_val)
  begin
    $display("FAILED %s: expected %s, actual %s", name, exp_val.name(), act_val.name());
    fail_stop();
  end
endtask

function automatic lsu_req_t make_lsu(input logic [31:0] addr, input logic we,
                                      input logic [3:0] be, input logic [31:0] wdata);
  lsu_req_t r;
  r.addr  = addr;
  r.we    = we;
  r.be    = be;
  r.wdata = wdata;
  return r;
endfunction

function automatic line_req_t make_line(input logic [11:0] addr, input logic we,
                                        input logic [7:0] be, input logic [63:0] wdata);
  line_req_t r;
  r.addr  = addr;
  r.we    = we;
  r.be    = be;
  r.wdata = wdata;
  return r;
endfunction

// known start value, every address bit shows up in it
function automatic logic [`CR_LINE_W-1:0] line_fill(input logic [11:0] a);
  return {20'hF0F0F, a, 20'h0A0A0, a};
endfunction

task automatic host_write(input line_req_t req);
  @(posedge clk);
  host_req_i <= 1'b1;
  host_i     <= req;
  @(posedge clk);
  host_req_i <= 1'b0;
  model_line_write(req);
endtask

task automatic host_read(input string name, input logic [11:0] addr);
  @(posedge clk);
  host_req_i <= 1'b1;
  host_i     <= make_line(addr, 1'b0, 8'h00, 64'd0);
  @(posedge clk);
  host_req_i <= 1'b0;
  @(negedge clk);
  check_line(name, mem_model[addr[`CR_RAM_ADDR_W-1:3]], host_rdata_o);
endtask

task automatic fill_lines(input logic [11:0] base, input int count);
  logic [11:0] addr;
  addr = base;
  for (int i = 0; i < count; i++)
  begin
    host_write(make_line(addr, 1'b1, 8'hFF, line_fill(addr)));
    addr = addr + 12'd8;
  end
endtask

// request is already driven, wait for grant and response and check both
task automatic lsu_complete(input string name, input lsu_req_t req);
  logic        is_local;
  logic [31:0] gnt_wait;
  logic [31:0] rsp_wait;
  resp_src_e   exp_src;
  resp_src_e   seen_src;
  is_local = (req.addr[`CR_PAGE_MSB:`CR_PAGE_LSB] == `CR_LOCAL_PAGE);
  exp_src  = is_local ? RESP_RAM : RESP_EXT;
  gnt_wait = '0;
  @(negedge clk);
  while (!lsu_gnt_o)
  begin
    gnt_wait++;
    if (gnt_wait > RESP_TIMEOUT)
    begin
      $display("no grant for %s within %0d cycles", name, RESP_TIMEOUT);
      fail_stop();
    end
    @(negedge clk);
  end
  seen_src = ext_req_o ? RESP_EXT : RESP_RAM;
  check_src({name, " source"}, exp_src, seen_src);
  check_word({name, " grant wait"}, is_local ? 32'd0 : ext_wait_next + 32'd1, gnt_wait);
  @(posedge clk);
  lsu_req_i <= 1'b0;
  if (is_local && req.we)
    model_lsu_write(req);
  rsp_wait = '0;
  do
  begin
    @(negedge clk);
    rsp_wait++;
    if (rsp_wait > RESP_TIMEOUT)
    begin
      $display("no response for %s within %0d cycles", name, RESP_TIMEOUT);
      fail_stop();
    end
  end
  while (!lsu_rvalid_o);
  check_word({name, " latency"}, is_local ? 32'd1 : 32'd2, rsp_wait);
  if (!req.we)
    check_word(name, is_local ? model_word(req.addr) : req.addr ^ 32'hA5A5A5A5, lsu_rdata_o);
endtask

task automatic lsu_access(input string name, input lsu_req_t req);
  // the bus model picks up its grant wait from here
  if (req.addr[`CR_PAGE_MSB:`CR_PAGE_LSB] != `CR_LOCAL_PAGE)
    ext_wait_next = lfsr_bits(2);
  @(posedge clk);
  lsu_req_i <= 1'b1;
  lsu_i     <= req;
  lsu_complete(name, req);
endtask

task automatic local_word_lanes();
  lsu_access("t1 write lower", make_lsu(32'h00100008, 1'b1, 4'hF, 32'h11223344));
  lsu_access("t1 write upper", make_lsu(32'h0010000C, 1'b1, 4'hF, 32'hAABBCCDD));
  lsu_access("t1 read lower", make_lsu(32'h00100008, 1'b0, 4'hF, 32'd0));
  lsu_access("t1 read upper", make_lsu(32'h0010000C, 1'b0, 4'hF, 32'd0));
endtask

task automatic host_lsu_views();
  fill_lines(12'h040, 1);
  host_write(make_line(12'h040, 1'b1, 8'h0F, 64'h0123456789ABCDEF));
  host_write(make_line(12'h048, 1'b1, 8'hFF, 64'hFEDCBA9876543210));
  lsu_access("t2 read 040", make_lsu(32'h00100040, 1'b0, 4'hF, 32'd0));
  lsu_access("t2 read 044", make_lsu(32'h00100044, 1'b0, 4'hF, 32'd0));
  lsu_access("t2 read 048", make_lsu(32'h00100048, 1'b0, 4'hF, 32'd0));
  lsu_access("t2 read 04c", make_lsu(32'h0010004C, 1'b0, 4'hF, 32'd0));
  lsu_access("t2 write 050", make_lsu(32'h00100050, 1'b1, 4'hF, 32'h5555AAAA));
  lsu_access("t2 write 054", make_lsu(32'h00100054, 1'b1, 4'hF, 32'h3C3CC3C3));
  host_read("t2 host read 050", 12'h050);
endtask

task automatic host_priority();
  line_req_t hreq;
  lsu_req_t  rd;
  hreq = make_line(12'h060, 1'b1, 8'hF0, 64'hCAFEF00D_DEADBEEF);
  rd   = make_lsu(32'h00100064, 1'b0, 4'hF, 32'd0);
  fill_lines(12'h060, 1);
  // both ports ask in the same cycle
  @(posedge clk);
  host_req_i <= 1'b1;
  host_i     <= hreq;
  lsu_req_i  <= 1'b1;
  lsu_i      <= rd;
  @(negedge clk);
  check_word("t3 grant during host", 32'd0, {31'd0, lsu_gnt_o});
  @(posedge clk);
  host_req_i <= 1'b0;
  model_line_write(hreq);
  lsu_complete("t3 read after host", rd);
endtask

task automatic external_routing();
  fill_lines(12'h010, 1);
  lsu_access("t4 ext write", make_lsu(32'h40000010, 1'b1, 4'hC, 32'h13579BDF));
  check_word("t4 ext addr", 32'h40000010, ext_seen.addr);
  check_word("t4 ext wdata", 32'h13579BDF, ext_seen.wdata);
  check_word("t4 ext we be", {27'd0, 1'b1, 4'hC}, {27'd0, ext_seen.we, ext_seen.be});
  // same offset in the RAM must still hold its fill
  lsu_access("t4 local after ext", make_lsu(32'h00100010, 1'b0, 4'hF, 32'd0));
  lsu_access("t4 ext read", make_lsu(32'h40000014, 1'b0, 4'hF, 32'd0));
endtask

task automatic random_local_traffic();
  logic [31:0] we_bit;
  logic [31:0] widx;
  logic [31:0] be_bits;
  logic [31:0] wdata;
  fill_lines(12'h100, 16);
  for (int i = 0; i < 32; i++)
  begin
    we_bit  = lfsr_bits(1);
    widx    = lfsr_bits(5);
    be_bits = lfsr_bits(4);
    wdata   = lfsr_bits(32);
    lsu_access($sformatf("t5 op %0d", i),
               make_lsu(32'h00100100 + (widx << 2), we_bit[0], be_bits[3:0], wdata));
  end
endtask

`endif

// ==== tb_core_region.sv ====
`timescale 1ns/1ns

`include "core_region_defines.svh"

module tb_core_region import core_region_pkg::*;
;

  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 100;
  localparam int RESP_TIMEOUT    = 50;

  logic                  clk;
  logic                  rst_n;
  logic                  lsu_req_i;
  lsu_req_t              lsu_i;
  logic                  lsu_gnt_o;
  logic                  lsu_rvalid_o;
  logic [`CR_WORD_W-1:0] lsu_rdata_o;
  logic                  ext_req_o;
  lsu_req_t              ext_o;
  logic                  ext_gnt_i;
  logic                  ext_rvalid_i;
  logic [`CR_WORD_W-1:0] ext_rdata_i;
  logic                  host_req_i;
  line_req_t             host_i;
  logic [`CR_LINE_W-1:0] host_rdata_o;

  // reference copy of the data RAM contents
  logic [`CR_LINE_W-1:0] mem_model [`CR_RAM_BYTES / 8];
  logic [31:0]           lfsr_state;
  logic [31:0]           ext_wait_next;
  lsu_req_t              ext_seen;

  core_region_top i_dut (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_i        ( lsu_i        ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ext_req_o    ( ext_req_o    ),
    .ext_o        ( ext_o        ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  ),
    .host_req_i   ( host_req_i   ),
    .host_i       ( host_i       ),
    .host_rdata_o ( host_rdata_o )
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "watchdog timeout");
  end

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val = {val[30:0], lfsr_state[0]};
      if (lfsr_state[0])
        lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
      else
        lfsr_state = lfsr_state >> 1;
    end
    return val;
  endfunction

  // external bus slave with a random grant wait and a fixed two cycle answer
  initial
  begin : ext_bus_model
    ext_gnt_i    <= 1'b0;
    ext_rvalid_i <= 1'b0;
    ext_rdata_i  <= '0;
    forever
    begin
      @(negedge clk);
      if (rst_n && ext_req_o)
      begin
        repeat (ext_wait_next) @(posedge clk);
        @(posedge clk);
        ext_gnt_i <= 1'b1;
        @(negedge clk);
        ext_seen = ext_o;
        @(posedge clk);
        ext_gnt_i <= 1'b0;
        @(posedge clk);
        ext_rvalid_i <= 1'b1;
        ext_rdata_i  <= ext_seen.addr ^ 32'hA5A5A5A5;
        @(posedge clk);
        ext_rvalid_i <= 1'b0;
      end
    end
  end

  task automatic fail_stop();
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic logic [`CR_WORD_W-1:0] model_word(input logic [31:0] addr);
    logic [`CR_LINE_W-1:0] line;
    line = mem_model[addr[`CR_RAM_ADDR_W-1:3]];
    return addr[2] ? line[63:32] : line[31:0];
  endfunction

  task automatic model_lsu_write(input lsu_req_t req);
    logic [`CR_RAM_ADDR_W-4:0] idx;
    int                        base;
    idx  = req.addr[`CR_RAM_ADDR_W-1:3];
    base = req.addr[2] ? 32 : 0;
    for (int b = 0; b < `CR_BE_W; b++)
    begin
      if (req.be[b])
        mem_model[idx][base + b*8 +: 8] = req.wdata[b*8 +: 8];
    end
  endtask

  task automatic model_line_write(input line_req_t req);
    logic [`CR_RAM_ADDR_W-4:0] idx;
    idx = req.addr[`CR_RAM_ADDR_W-1:3];
    for (int b = 0; b < `CR_LINE_BE_W; b++)
    begin
      if (req.be[b])
        mem_model[idx][b*8 +: 8] = req.wdata[b*8 +: 8];
    end
  endtask

  `include "tb_core_region_checks.svh"

  initial
  begin
    rst_n      <= 1'b0;
    lsu_req_i  <= 1'b0;
    lsu_i      <= '0;
    host_req_i <= 1'b0;
    host_i     <= '0;
    lfsr_state    = 32'd38;
    ext_wait_next = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_word("reset state", 32'd0, {29'd0, lsu_rvalid_o, lsu_gnt_o, ext_req_o});

    local_word_lanes();
    host_lsu_views();
    host_priority();
    external_routing();
    random_local_traffic();

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== core_region.f ====
+incdir+.
core_region_pkg.sv
lsu_demux.sv
data_ram_arbiter.sv
data_ram.sv
core_region_top.sv
tb_core_region.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_core_region \
  -f core_region.f \
  --Mdir obj_dir -o sim_core_region
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_core_region > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
